//--- bench/mem_input.txt
# op(W/R) addr(hex, 21 bit) wdata flip | expected rdata and parity_err in the done cycle
# Writes expect rdata 00 as Q is gated, reads carry wdata 00 and flip 0
# Write then read back
W 000123 A5 0 00 0
R 000123 00 0 A5 0
W 03C0F0 69 0 00 0
R 03C0F0 00 0 69 0
# Same row and column in both banks
W 012345 3C 0 00 0
W 112345 C3 0 00 0
R 012345 00 0 3C 0
R 112345 00 0 C3 0
W 000401 11 0 00 0
W 000801 22 0 00 0
R 000401 00 0 11 0
R 000801 00 0 22 0
# Flipped parity, then a clean rewrite
W 004567 5A 1 00 0
R 004567 00 0 5A 1
W 004567 5A 0 00 0
R 004567 00 0 5A 0
W 1003FF 00 1 00 0
R 1003FF 00 0 00 1
W 1003FF 7E 0 00 0
R 1003FF 00 0 7E 0
W 002400 FF 1 00 0
R 002400 00 0 FF 1
W 000123 17 0 00 0
R 002400 00 0 FF 1
R 000123 00 0 17 0
# Address corners in both banks
W 000000 00 0 00 0
W 07FFFF FF 0 00 0
W 100000 01 0 00 0
W 17FFFF 80 0 00 0
R 000000 00 0 00 0
R 07FFFF 00 0 FF 0
R 100000 00 0 01 0
R 17FFFF 00 0 80 0

//--- filelist.f
src/nd_mem_pkg.sv
src/dram_timing_ctrl.sv
src/sip1m9.sv
src/parity_path.sv
src/mem_subsystem_top.sv
bench/mem_subsystem_assertions.sv
bench/tb_mem_subsystem.sv

//--- Makefile
# Verilator flow for the memory subsystem testbench
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module tb_mem_subsystem \
	  -f filelist.f -Mdir $(BUILD) -o sim_tb

run: compile
	./$(BUILD)/sim_tb | tee $(LOG)
	@grep -q "^Done: no errors" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_mem_subsystem.sv
//////////////////////////////////////////////////
// Memory subsystem testbench
// File-driven accesses with LFSR fill traffic,
// checked against a sparse reference memory
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
  import nd_mem_pkg::*;
();

  typedef struct packed {
    logic                      is_write;
    logic [HOST_ADDR_BITS-1:0] addr;
    logic [7:0]                wdata;
    logic                      flip;
    logic [7:0]                exp_data;  // rdata seen in the done cycle
    logic                      exp_err;
  } cmd_t;

  logic       sysclk;
  logic       rst_n;
  logic       req;
  mem_req_t   req_data;
  logic       busy;
  logic       done;
  logic [7:0] rdata;
  logic       parity_err;

  cmd_t                      cmds [$];
  logic [7:0]                ref_mem [logic [HOST_ADDR_BITS-1:0]];  // Sparse model
  logic [HOST_ADDR_BITS-1:0] fill_addrs [$];  // Fill addresses written so far
  logic [31:0]               lfsr_q;
  int                        mismatches;
  int                        failures;
  longint                    limit_ns;  // Watchdog budget, set after loading

  mem_subsystem_top i_mem_subsystem_top (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .req        (req),
    .req_data   (req_data),
    .busy       (busy),
    .done       (done),
    .rdata      (rdata),
    .parity_err (parity_err)
  );

  initial begin
    sysclk = 1'b0;
    forever #50 sysclk = ~sysclk;  // 100 ns period
  end

  // Galois step, right shift, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};  // One step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      failures++;
      $display("Error at %0d ns: %s", $time, what);
    end
  endtask

  task automatic load_commands();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] f;
    logic [31:0] ed;
    logic [31:0] ee;
    cmd_t        c;
    fd = $fopen("bench/mem_input.txt", "r");
    if (fd == 0) begin
      expect_true(1'b0, "could not open bench/mem_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
      n = $sscanf(line, "%s %h %h %h %h %h", op, a, d, f, ed, ee);
      if (n != 6 || (op != "W" && op != "R")) begin
        expect_true(1'b0, "input file holds a line that cannot be parsed");
        continue;
      end
      c.is_write = (op == "W");
      c.addr     = a[HOST_ADDR_BITS-1:0];
      c.wdata    = d[7:0];
      c.flip     = f[0];
      c.exp_data = ed[7:0];
      c.exp_err  = ee[0];
      cmds.push_back(c);
    end
    $fclose(fd);
  endtask

  // One host access, req to done, latency and busy checked on the way
  task automatic run_access(input logic is_write, input logic [HOST_ADDR_BITS-1:0] addr,
                            input logic [7:0] wdata, input logic flip,
                            output logic [7:0] got_data, output logic got_err);
    int cycles;
    @(negedge sysclk);
    req               = 1'b1;  // Cycle 0
    req_data.addr     = addr;
    req_data.wdata    = wdata;
    req_data.we       = is_write;
    req_data.par_flip = flip;
    @(negedge sysclk);
    req      = 1'b0;
    req_data = '0;
    cycles   = 1;
    while (!done && cycles < 20) begin
      expect_true(busy, "busy was low while an access was in flight");
      @(negedge sysclk);
      cycles++;
    end
    if (!done) begin
      expect_true(1'b0, "done never arrived after req");
    end else begin
      compare_value("done latency", 32'd8, 32'(cycles));
      expect_true(busy, "busy was low in the done cycle");
    end
    got_data = rdata;
    got_err  = parity_err;
    @(negedge sysclk);
    expect_true(!busy, "busy stayed high the cycle after done");
    expect_true(!done, "done lasted more than one cycle");
  endtask

  // Random write, then a read back of some earlier fill address
  task automatic fill_step();
    logic [31:0]               a_bits;
    logic [31:0]               d_bits;
    logic [31:0]               pick;
    logic [HOST_ADDR_BITS-1:0] addr;
    logic [7:0]                got_d;
    logic                      got_e;
    int                        idx;
    draw_bits(HOST_ADDR_BITS, a_bits);
    draw_bits(8, d_bits);
    addr = a_bits[HOST_ADDR_BITS-1:0] | 21'h08_0000;  // Bit 19 set, file lines keep it clear
    run_access(1'b1, addr, d_bits[7:0], 1'b0, got_d, got_e);
    compare_value("rdata", 32'h0, 32'(got_d));  // Q gated off on writes
    compare_value("parity_err", 32'h0, 32'(got_e));
    if (!ref_mem.exists(addr)) fill_addrs.push_back(addr);
    ref_mem[addr] = d_bits[7:0];
    draw_bits(8, pick);
    idx  = int'(pick[7:0]) % fill_addrs.size();
    addr = fill_addrs[idx];
    run_access(1'b0, addr, 8'h00, 1'b0, got_d, got_e);
    compare_value("rdata", 32'(ref_mem[addr]), 32'(got_d));
    compare_value("parity_err", 32'h0, 32'(got_e));
  endtask

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    cmd_t       c;
    logic [7:0] got_d;
    logic       got_e;
    rst_n      = 1'b0;
    req        = 1'b0;
    req_data   = '0;
    lfsr_q     = 32'h730f;
    mismatches = 0;
    failures   = 0;
    limit_ns   = 0;
    load_commands();
    // Three accesses per line, 12 cycles each, plus reset and slack
    limit_ns = (longint'(cmds.size()) * 3 * 12 + 60) * 100;
    repeat (4) @(negedge sysclk);
    rst_n = 1'b1;
    compare_value("busy", 32'h0, 32'(busy));  // Idle values after reset
    compare_value("done", 32'h0, 32'(done));
    compare_value("rdata", 32'h0, 32'(rdata));
    compare_value("parity_err", 32'h0, 32'(parity_err));
    foreach (cmds[i]) begin
      c = cmds[i];
      run_access(c.is_write, c.addr, c.wdata, c.flip, got_d, got_e);
      compare_value("rdata", 32'(c.exp_data), 32'(got_d));
      compare_value("parity_err", 32'(c.exp_err), 32'(got_e));
      fill_step();
    end
    $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/mem_subsystem_assertions.sv
//////////////////////////////////////////////////
// Controller protocol assertions
// Strobe ordering, done timing and request rules
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assertions
  import nd_mem_pkg::*;
(
  input logic                 sysclk,
  input logic                 rst_n,
  input logic                 req,
  input logic                 accept,  // Request taken in IDLE
  input dram_bus_t            bus,
  input logic [NUM_BANKS-1:0] ras_n,
  input logic                 busy,
  input logic                 done
);

  // CAS edge only inside an open row
  cas_inside_ras: assert property (@(posedge sysclk) disable iff (!rst_n)
    $fell(bus.cas_n) |-> (ras_n != '1))
    else $error("CAS fell while every RAS was high");

  done_one_cycle: assert property (@(posedge sysclk) disable iff (!rst_n)
    done |=> !done)
    else $error("done held for more than one cycle");

  // Fixed 8-cycle access
  done_latency: assert property (@(posedge sysclk) disable iff (!rst_n)
    done |-> $past(accept, 8))
    else $error("done not 8 cycles after an accepted req");

  no_req_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
    busy |-> !req)
    else $error("req arrived while busy");

endmodule

bind dram_timing_ctrl mem_subsystem_assertions i_ctrl_assertions (
  .sysclk (sysclk),
  .rst_n  (rst_n),
  .req    (req),
  .accept (accept),
  .bus    (bus),
  .ras_n  (ras_n),
  .busy   (busy),
  .done   (done)
);

`default_nettype wire

//--- src/mem_subsystem_top.sv
//////////////////////////////////////////////////
// Parity-protected memory subsystem
// Controller, two SIP banks and the parity path
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
  import nd_mem_pkg::*;
(
  input  logic       sysclk,
  input  logic       rst_n,
  input  logic       req,
  input  mem_req_t   req_data,
  output logic       busy,
  output logic       done,
  output logic [7:0] rdata,
  output logic       parity_err
);

  dram_bus_t            bus;
  logic [NUM_BANKS-1:0] ras_n;
  logic                 capture;
  logic                 bank;
  logic                 wr_d9;
  sip_out_t             sip_out [NUM_BANKS];

  dram_timing_ctrl i_ctrl (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .wr_d9    (wr_d9),
    .bus      (bus),
    .ras_n    (ras_n),
    .capture  (capture),
    .bank     (bank),
    .busy     (busy),
    .done     (done)
  );

  // Parity bit formed while req_data is presented, controller keeps it
  parity_path i_parity (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .wdata      (req_data.wdata),
    .par_flip   (req_data.par_flip),
    .wr_d9      (wr_d9),
    .capture    (capture),
    .bank       (bank),
    .is_read    (bus.w_n),  // W_n stays low through capture on writes
    .sip_out    (sip_out),
    .rdata      (rdata),
    .parity_err (parity_err)
  );

  // Shared bus, one RAS per module
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_sip
    sip1m9 i_sip (
      .sysclk (sysclk),
      .rst_n  (rst_n),
      .bus    (bus),
      .ras_n  (ras_n[b]),
      .dout   (sip_out[b])
    );
  end

endmodule

`default_nettype wire

//--- src/parity_path.sv
//////////////////////////////////////////////////
// Parity path
// Makes the write parity bit and captures the read
// byte and parity error of the selected bank
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module parity_path
  import nd_mem_pkg::*;
(
  input  logic       sysclk,
  input  logic       rst_n,
  input  logic [7:0] wdata,
  input  logic       par_flip,             // Diagnostic wrong parity
  output logic       wr_d9,
  input  logic       capture,              // From the controller
  input  logic       bank,
  input  logic       is_read,
  input  sip_out_t   sip_out [NUM_BANKS],
  output logic [7:0] rdata,
  output logic       parity_err
);

  sip_out_t sel;

  // Ninth bit makes the word even, flip breaks it on purpose
  assign wr_d9 = (^wdata) ^ par_flip;

  assign sel = sip_out[bank];  // Only the addressed module drove a read

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      rdata      <= 8'h00;
      parity_err <= 1'b0;
    end else if (capture) begin
      rdata <= sel.q8;  // Zero on writes since Q is gated
      if (is_read) begin
        parity_err <= !sel.prd_n;
      end else begin
        parity_err <= 1'b0;  // Write clears a stale error
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sip1m9.sv
//////////////////////////////////////////////////
// 1 MB x 9 SIP DRAM module
// Strobe edges sampled on sysclk, data and parity
// arrays in block RAM, gated Q and parity check
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sip1m9
  import nd_mem_pkg::*;
(
  input  logic      sysclk,
  input  logic      rst_n,
  input  dram_bus_t bus,
  input  logic      ras_n,  // This module's own RAS
  output sip_out_t  dout
);

  (* ram_style = "block" *) logic [7:0] data_mem [SIP_DEPTH];  // 1 MB
  (* ram_style = "block" *) logic       par_mem  [SIP_DEPTH];  // 1 Mbit

  logic                     ras_n_q;  // Strobe levels one clock back
  logic                     cas_n_q;
  logic                     ras_fall;
  logic                     cas_fall;
  logic [ROW_BITS-1:0]      row_q;
  logic [SIP_ADDR_BITS-1:0] sip_addr;
  logic [7:0]               q8_q;
  logic                     q9_q;
  logic                     rd_active;

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      ras_n_q <= 1'b1;  // Idle strobes are high
      cas_n_q <= 1'b1;
    end else begin
      ras_n_q <= ras_n;
      cas_n_q <= bus.cas_n;
    end
  end

  // First cycle each strobe is seen low
  assign ras_fall = ras_n_q && !ras_n;
  assign cas_fall = cas_n_q && !bus.cas_n;

  // Row half captured at the RAS edge
  always_ff @(posedge sysclk) begin
    if (ras_fall) begin
      row_q <= bus.address;
    end
  end

  assign sip_addr = {row_q, bus.address};  // Column comes with CAS

  // Access at the CAS edge, only inside a RAS cycle
  always_ff @(posedge sysclk) begin
    if (cas_fall && !ras_n) begin
      if (bus.w_n) begin
        q8_q <= data_mem[sip_addr];  // Read into output latch
        q9_q <= par_mem[sip_addr];
      end else begin
        data_mem[sip_addr] <= bus.d8;
        par_mem[sip_addr]  <= bus.d9;
      end
    end
  end

  // Q drives only while CAS is low on a read
  assign rd_active = !bus.cas_n && bus.w_n;

  assign dout.q8 = rd_active ? q8_q : 8'h00;
  assign dout.q9 = rd_active ? q9_q : 1'b0;

  // Even parity over all nine outputs, low when odd
  assign dout.prd_n = !(^{dout.q8, dout.q9});

endmodule

`default_nettype wire

//--- src/dram_timing_ctrl.sv
//////////////////////////////////////////////////
// DRAM timing controller
// Turns a host strobe into a row/column cycle with
// RAS, CAS and W edges, then signals completion
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dram_timing_ctrl
  import nd_mem_pkg::*;
(
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  logic                 req,
  input  mem_req_t             req_data,
  input  logic                 wr_d9,     // Parity bit for the byte on req_data
  output dram_bus_t            bus,
  output logic [NUM_BANKS-1:0] ras_n,     // One RAS per bank
  output logic                 capture,   // Last CAS-low cycle
  output logic                 bank,
  output logic                 busy,
  output logic                 done
);

  ctrl_state_e         state_q;
  ctrl_state_e         state_d;
  logic [CNT_BITS-1:0] cnt_q;
  logic [CNT_BITS-1:0] cnt_d;
  mem_req_t            req_q;   // Request held for the whole cycle
  logic                d9_q;    // Parity bit taken with the request
  logic                accept;
  logic                ras_low;
  logic                w_low;

  // Requests while busy are dropped
  assign accept = (state_q == IDLE) && req;

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Payload copy, only loaded on accept
  always_ff @(posedge sysclk) begin
    if (accept) begin
      req_q <= req_data;
      d9_q  <= wr_d9;
    end
  end

  // Sequencing with a down-counter per timed phase
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = ROW_SETUP;  // Single cycle, no count
        end
      end
      ROW_SETUP: begin
        state_d = RAS_ACTIVE;
        cnt_d   = CNT_BITS'(T_RAS_TO_CAS - 1);
      end
      RAS_ACTIVE: begin
        if (cnt_q == '0) begin
          state_d = CAS_ACTIVE;
          cnt_d   = CNT_BITS'(T_CAS_HOLD - 1);
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      CAS_ACTIVE: begin
        if (cnt_q == '0) begin
          state_d = PRECHARGE;
          cnt_d   = CNT_BITS'(T_PRECHARGE - 1);
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      PRECHARGE: begin
        if (cnt_q == '0) begin
          state_d = DONE;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign bank = req_q.addr[HOST_ADDR_BITS-1];  // Top address bit

  // RAS held low through the CAS phase
  assign ras_low = (state_q == RAS_ACTIVE) || (state_q == CAS_ACTIVE);

  // Write enable set up with the row, released at precharge
  assign w_low = req_q.we &&
                 ((state_q == ROW_SETUP) || ras_low);

  always_comb begin
    ras_n = '1;
    if (ras_low) begin
      ras_n[bank] = 1'b0;  // Only the addressed bank
    end
  end

  always_comb begin
    bus       = '0;
    bus.cas_n = (state_q != CAS_ACTIVE);  // CAS9 tied to CAS
    bus.w_n   = !w_low;
    bus.d8    = req_q.wdata;
    bus.d9    = d9_q;
    case (state_q)
      ROW_SETUP, RAS_ACTIVE: bus.address = req_q.addr[SIP_ADDR_BITS-1:ROW_BITS];
      CAS_ACTIVE, PRECHARGE: bus.address = req_q.addr[ROW_BITS-1:0];
      default:               bus.address = '0;
    endcase
  end

  // Read byte is on Q in the second CAS-low cycle
  assign capture = (state_q == CAS_ACTIVE) && (cnt_q == '0);
  assign busy    = (state_q != IDLE);
  assign done    = (state_q == DONE);

endmodule

`default_nettype wire

//--- src/nd_mem_pkg.sv
//////////////////////////////////////////////////
// Memory subsystem shared definitions
// Address widths, strobe timing counts, controller
// states and the request and DRAM bus bundles
//////////////////////////////////////////////////
`default_nettype none

package nd_mem_pkg;

  // Address geometry
  localparam int ROW_BITS       = 10;  // Row or column half
  localparam int SIP_ADDR_BITS  = 20;  // Row then column
  localparam int HOST_ADDR_BITS = 21;  // Top bit picks the bank
  localparam int NUM_BANKS      = 2;
  localparam int SIP_DEPTH      = 2 ** SIP_ADDR_BITS;  // 1M locations per module

  // Strobe timing in sysclk cycles
  localparam int T_RAS_TO_CAS = 2;  // RAS low before CAS falls
  localparam int T_CAS_HOLD   = 2;  // CAS low time
  localparam int T_PRECHARGE  = 2;  // Both strobes high after access
  localparam int CNT_BITS     = 2;  // Wide enough for the largest count above

  // Controller sequence
  typedef enum logic [2:0] {
    IDLE,
    ROW_SETUP,   // Row on the bus, strobes still high
    RAS_ACTIVE,
    CAS_ACTIVE,
    PRECHARGE,
    DONE
  } ctrl_state_e;

  // Host request, valid with the req strobe
  typedef struct packed {
    logic [HOST_ADDR_BITS-1:0] addr;
    logic [7:0]                wdata;
    logic                      we;        // 1 = write
    logic                      par_flip;  // Diagnostic, store wrong parity
  } mem_req_t;

  // Lines shared by both SIP modules
  typedef struct packed {
    logic [ROW_BITS-1:0] address;  // Multiplexed row/column
    logic                cas_n;    // CAS9 rides on this too
    logic                w_n;
    logic [7:0]          d8;
    logic                d9;       // Parity bit in
  } dram_bus_t;

  // Outputs of one SIP module
  typedef struct packed {
    logic [7:0] q8;
    logic       q9;
    logic       prd_n;  // Low on odd parity
  } sip_out_t;

endpackage

`default_nettype wire
